// ==== verilog.f ====
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_rx_shift.sv
logic/uart_rx_ctrl.sv
logic/uart_tx.sv
logic/uart_top.sv
dv/uart_checker.sv
dv/uart_monitor.sv
dv/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = uart_tb
FILELIST  = verilog.f
LOG       = sim.log
SIM       = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(SIM) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "all tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/uart_tb.sv ====
// uart testbench top
module uart_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CLKS     = 64;
    localparam int RESET_CYCLES = 10;
    localparam int N_ROWS       = 12;
    localparam int LIMIT        = N_ROWS * 12 * BIT_CLKS + RESET_CYCLES + 1000;
    localparam int K_RX   = 0;
    localparam int K_BAD  = 1;
    localparam int K_TX   = 2;
    localparam int K_BUSY = 3;

    logic       clk = 1'b0;
    logic       reset_i = 1'b1;
    logic       rx_i = 1'b1;
    logic [7:0] tx_data_i = '0;
    logic       tx_load_i = 1'b0;
    logic       tx_o;
    logic       tx_ready_o;
    logic [7:0] rx_data_o;
    logic       rx_valid_o;
    logic       rx_frame_err_o;

    string      row_name[N_ROWS];
    int         row_kind[N_ROWS];
    logic [7:0] row_byte[N_ROWS];
    int         row_gap[N_ROWS];
    int         seed = 32'h0fed_bb15;
    int         cycles = 0;

    always #20 clk = ~clk;

    uart_top #(.baud16_div(11'd3)) u_dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .rx_i           (rx_i),
        .tx_data_i      (tx_data_i),
        .tx_load_i      (tx_load_i),
        .tx_o           (tx_o),
        .tx_ready_o     (tx_ready_o),
        .rx_data_o      (rx_data_o),
        .rx_valid_o     (rx_valid_o),
        .rx_frame_err_o (rx_frame_err_o)
    );

    uart_monitor u_mon (
        .clk            (clk),
        .reset_i        (reset_i),
        .tx_i           (tx_o),
        .tx_ready_i     (tx_ready_o),
        .rx_data_i      (rx_data_o),
        .rx_valid_i     (rx_valid_o),
        .rx_frame_err_i (rx_frame_err_o)
    );

    bind uart_top uart_checker u_checker (
        .clk            (clk),
        .reset_i        (reset_i),
        .tx_load_i      (tx_load_i),
        .tx_i           (tx_o),
        .tx_ready_i     (tx_ready_o),
        .rx_valid_i     (rx_valid_o),
        .rx_frame_err_i (rx_frame_err_o)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: test timed out waiting for a strobe");
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic set_row(input int i, input string name, input int kind,
                           input logic [7:0] b, input int gap);
        row_name[i] = name;
        row_kind[i] = kind;
        row_byte[i] = b;
        row_gap[i]  = gap;
    endtask

    // called on a falling edge
    task automatic drive_bit(input logic b);
        rx_i = b;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    task automatic send_rx(input logic [7:0] b, input logic stop, input int gap);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(stop);
        repeat (gap) drive_bit(1'b1);
    endtask

    task automatic load_tx(input logic [7:0] b);
        tx_data_i = b;
        tx_load_i = 1'b1;
        @(negedge clk);
        tx_load_i = 1'b0;
    endtask

    task automatic wait_ready();
        while (!tx_ready_o) @(negedge clk);
    endtask

    initial begin
        set_row(0, "rx_a5", K_RX, 8'ha5, 1);
        set_row(1, "rx_00", K_RX, 8'h00, 1);
        set_row(2, "rx_ff", K_RX, 8'hff, 1);
        set_row(3, "rx_b2b_0", K_RX, 8'h3c, 0); // back to back
        set_row(4, "rx_b2b_1", K_RX, 8'hc3, 0);
        set_row(5, "rx_b2b_2", K_RX, rand_byte(), 0);
        set_row(6, "rx_bad_stop", K_BAD, 8'h55, 2);
        set_row(7, "rx_rand", K_RX, rand_byte(), 1);
        set_row(8, "tx_5a", K_TX, 8'h5a, 0);
        set_row(9, "tx_rand", K_TX, rand_byte(), 0);
        set_row(10, "tx_load_busy", K_BUSY, 8'h96, 0);
        set_row(11, "rx_after_tx", K_RX, rand_byte(), 1);

        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);
        u_mon.check_after_reset("after_reset");
        repeat (4 * BIT_CLKS) @(negedge clk); // idle line, no strobe expected

        for (int i = 0; i < N_ROWS; i++) begin
            case (row_kind[i])
                K_RX, K_BAD: begin
                    u_mon.push_rx(row_name[i], row_byte[i], row_kind[i] == K_BAD);
                    send_rx(row_byte[i], row_kind[i] != K_BAD, row_gap[i]);
                end
                default: begin
                    u_mon.push_tx(row_name[i], row_byte[i]);
                    wait_ready();
                    load_tx(row_byte[i]);
                    if (row_kind[i] == K_BUSY) begin
                        repeat (3 * BIT_CLKS) @(negedge clk);
                        load_tx(~row_byte[i]); // dropped, ready is low
                    end
                    wait_ready();
                end
            endcase
        end

        while (u_mon.pending() != 0) @(negedge clk);
        repeat (2 * BIT_CLKS) @(negedge clk);
        $display("summary: %0d passed, %0d failed, %0d assertion failures",
                 u_mon.pass_cnt, u_mon.fail_cnt, u_dut.u_checker.fail_cnt);
        if (u_mon.fail_cnt == 0 && u_dut.u_checker.fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== dv/uart_monitor.sv ====
// uart port monitor
module uart_monitor (
    input logic       clk,
    input logic       reset_i,
    input logic       tx_i,
    input logic       tx_ready_i,
    input logic [7:0] rx_data_i,
    input logic       rx_valid_i,
    input logic       rx_frame_err_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CLKS = 64;

    string      rx_name_q[$];
    logic [7:0] rx_byte_q[$];
    bit         rx_bad_q[$];
    string      tx_name_q[$];
    logic [7:0] tx_byte_q[$];
    int         pass_cnt = 0;
    int         fail_cnt = 0;

    task automatic push_rx(input string name, input logic [7:0] b, input bit bad);
        rx_name_q.push_back(name);
        rx_byte_q.push_back(b);
        rx_bad_q.push_back(bad);
    endtask

    task automatic push_tx(input string name, input logic [7:0] b);
        tx_name_q.push_back(name);
        tx_byte_q.push_back(b);
    endtask

    function automatic int pending();
        return rx_name_q.size() + tx_name_q.size();
    endfunction

    task automatic report(input string name, input bit ok, input string msg);
        if (ok) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("%s", msg);
        end
    endtask

    task automatic check_after_reset(input string name);
        report(name, (tx_i === 1'b1) && (tx_ready_i === 1'b1),
               $sformatf("%s: tx_o or tx_ready_o not high after reset", name));
    endtask

    // rx strobes, one per expected frame
    always @(negedge clk) begin
        string      name;
        logic [7:0] b;
        bit         bad;
        if (!reset_i && (rx_valid_i || rx_frame_err_i)) begin
            if (rx_name_q.size() == 0) begin
                fail_cnt++;
                $display("unexpected rx strobe, data %h", rx_data_i);
            end else begin
                name = rx_name_q.pop_front();
                b    = rx_byte_q.pop_front();
                bad  = rx_bad_q.pop_front();
                if (bad != rx_frame_err_i) begin
                    report(name, 0, $sformatf("MISMATCH %s expected %s actual %s", name,
                           bad ? "frame_err" : "valid", rx_frame_err_i ? "frame_err" : "valid"));
                end else if (!bad && rx_data_i !== b) begin
                    report(name, 0, $sformatf("MISMATCH %s expected %h actual %h",
                           name, b, rx_data_i));
                end else begin
                    report(name, 1, "");
                end
            end
        end
    end

    // tx frame decode, every clock of every bit must match its first sample
    initial begin
        logic [9:0] frame;
        bit         steady;
        string      name;
        logic [7:0] b;
        forever begin
            @(negedge tx_i);
            if (!reset_i) begin
                steady = 1'b1;
                for (int j = 0; j < 10 * BIT_CLKS; j++) begin
                    @(negedge clk);
                    if (j % BIT_CLKS == 0) begin
                        frame[j / BIT_CLKS] = tx_i;
                    end else if (tx_i !== frame[j / BIT_CLKS]) begin
                        steady = 1'b0;
                    end
                end
                @(negedge clk);
                if (tx_name_q.size() == 0) begin
                    fail_cnt++;
                    $display("unexpected tx frame, data %h", frame[8:1]);
                end else begin
                    name = tx_name_q.pop_front();
                    b    = tx_byte_q.pop_front();
                    if (!steady) begin
                        report(name, 0, $sformatf("%s: a tx bit was not 64 clocks long", name));
                    end else if (frame[0] !== 1'b0 || frame[9] !== 1'b1) begin
                        report(name, 0, $sformatf("%s: bad tx start or stop bit", name));
                    end else if (frame[8:1] !== b) begin
                        report(name, 0, $sformatf("MISMATCH %s expected %h actual %h",
                               name, b, frame[8:1]));
                    end else if (!tx_ready_i) begin
                        report(name, 0, $sformatf("%s: tx_ready_o low after stop bit", name));
                    end else begin
                        report(name, 1, "");
                    end
                end
            end
        end
    end

endmodule

// ==== dv/uart_checker.sv ====
// uart port assertions
module uart_checker (
    input logic clk,
    input logic reset_i,
    input logic tx_load_i,
    input logic tx_i,
    input logic tx_ready_i,
    input logic rx_valid_i,
    input logic rx_frame_err_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0; // read by the testbench summary

    a_strobe_excl: assert property (@(posedge clk) disable iff (reset_i)
        !(rx_valid_i && rx_frame_err_i))
        else begin
            fail_cnt++;
            $error("rx_valid_o and rx_frame_err_o high together");
        end

    a_idle_high: assert property (@(posedge clk) disable iff (reset_i)
        tx_ready_i |-> tx_i)
        else begin
            fail_cnt++;
            $error("tx_o low while tx_ready_o is high");
        end

    // accepted load makes the transmitter busy
    a_load_busy: assert property (@(posedge clk) disable iff (reset_i)
        (tx_load_i && tx_ready_i) |=> !tx_ready_i)
        else begin
            fail_cnt++;
            $error("tx_ready_o still high after an accepted load");
        end

endmodule

// ==== logic/uart_top.sv ====
// uart 8n1 top level
module uart_top #(
    parameter uart_pkg::div_count_t baud16_div = uart_pkg::DEFAULT_DIV
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 rx_i,
    input  uart_pkg::uart_byte_t tx_data_i,
    input  logic                 tx_load_i,
    output logic                 tx_o,
    output logic                 tx_ready_o,
    output uart_pkg::uart_byte_t rx_data_o,
    output logic                 rx_valid_o,
    output logic                 rx_frame_err_o
);

    logic tick16;
    logic bit_tick;
    logic rx_level;
    logic rx_edge;
    logic cur_bit;
    logic bit_end;
    logic shift_en;

    uart_baud_gen #(
        .baud16_div (baud16_div)
    ) u_baud_gen (
        .clk        (clk),
        .reset_i    (reset_i),
        .tick16_o   (tick16),
        .bit_tick_o (bit_tick)
    );

    uart_rx_shift u_rx_shift (
        .clk        (clk),
        .reset_i    (reset_i),
        .rx_i       (rx_i),
        .tick16_i   (tick16),
        .bit_end_i  (bit_end),
        .shift_en_i (shift_en),
        .rx_level_o (rx_level),
        .rx_edge_o  (rx_edge),
        .cur_bit_o  (cur_bit),
        .data_o     (rx_data_o)
    );

    uart_rx_ctrl u_rx_ctrl (
        .clk            (clk),
        .reset_i        (reset_i),
        .tick16_i       (tick16),
        .rx_level_i     (rx_level),
        .rx_edge_i      (rx_edge),
        .cur_bit_i      (cur_bit),
        .bit_end_o      (bit_end),
        .shift_en_o     (shift_en),
        .rx_valid_o     (rx_valid_o),
        .rx_frame_err_o (rx_frame_err_o)
    );

    uart_tx u_tx (
        .clk        (clk),
        .reset_i    (reset_i),
        .bit_tick_i (bit_tick),
        .load_i     (tx_load_i),
        .data_i     (tx_data_i),
        .tx_o       (tx_o),
        .ready_o    (tx_ready_o)
    );

endmodule

// ==== logic/uart_tx.sv ====
// uart transmitter
module uart_tx (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 bit_tick_i,
    input  logic                 load_i,
    input  uart_pkg::uart_byte_t data_i,
    output logic                 tx_o,
    output logic                 ready_o
);
    import uart_pkg::*;

    logic [TX_FRAME_W-1:0] frame_q;
    bit_count_t            bit_cnt;  // bit ticks since load
    logic                  load_ok;

    assign load_ok = load_i && ready_o; // loads while busy are dropped

    // leading 1 keeps the line idle until the next bit tick
    always_ff @(posedge clk) begin
        if (reset_i) begin
            frame_q <= '1;
        end else if (load_ok) begin
            frame_q <= {1'b1, data_i, 1'b0, 1'b1};
        end else if (bit_tick_i) begin
            frame_q <= {1'b1, frame_q[TX_FRAME_W-1:1]};
        end
    end

    assign tx_o = frame_q[0];

    // saturates at TX_DONE once the stop bit is out
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bit_cnt <= TX_DONE;
        end else if (load_ok) begin
            bit_cnt <= '0;
        end else if (bit_tick_i && !ready_o) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign ready_o = (bit_cnt == TX_DONE);

endmodule

// ==== logic/uart_rx_ctrl.sv ====
// uart receive control
module uart_rx_ctrl (
    input  logic clk,
    input  logic reset_i,
    input  logic tick16_i,
    input  logic rx_level_i,
    input  logic rx_edge_i,
    input  logic cur_bit_i,
    output logic bit_end_o,
    output logic shift_en_o,
    output logic rx_valid_o,
    output logic rx_frame_err_o
);
    import uart_pkg::*;

    rx_state_t     state_q;
    rx_state_t     state_d;
    sample_count_t sample_cnt;
    bit_count_t    bit_cnt;
    logic          fall_edge;
    logic          edge_end;
    logic          valid_q;
    logic          err_q;

    assign fall_edge = rx_edge_i && !rx_level_i;

    // an edge just after a counted bit end only realigns, so the bit is not closed twice
    assign edge_end   = rx_edge_i && ((state_q == RX_IDLE) || (sample_cnt >= HALF_BIT));
    assign bit_end_o  = (sample_cnt == SAMPLES_PER_BIT) || edge_end;
    assign shift_en_o = (state_q == RX_DATA);

    // position within the bit, restarted on every line edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sample_cnt <= '0;
        end else if (rx_edge_i || bit_end_o) begin
            sample_cnt <= '0;
        end else if (tick16_i) begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_IDLE: begin
                if (fall_edge) begin
                    state_d = RX_START;
                end
            end
            RX_START: begin
                if (bit_end_o) begin
                    if (!cur_bit_i) begin
                        state_d = RX_DATA;
                    end else begin
                        state_d = fall_edge ? RX_START : RX_IDLE; // false start
                    end
                end
            end
            RX_DATA: begin
                if (bit_end_o && (bit_cnt == LAST_DATA_BIT)) begin
                    state_d = RX_STOP;
                end
            end
            RX_STOP: begin
                if (bit_end_o) begin
                    // next start bit may close the stop bit itself
                    state_d = fall_edge ? RX_START : RX_IDLE;
                end
            end
            default: state_d = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= RX_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bit_cnt <= '0;
        end else if (state_q != RX_DATA) begin
            bit_cnt <= '0;
        end else if (bit_end_o) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // stop bit decides between byte and framing error
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            valid_q <= (state_q == RX_STOP) && bit_end_o && cur_bit_i;
            err_q   <= (state_q == RX_STOP) && bit_end_o && !cur_bit_i;
        end
    end

    assign rx_valid_o     = valid_q;
    assign rx_frame_err_o = err_q;

endmodule

// ==== logic/uart_rx_shift.sv ====
// uart receive sampler
module uart_rx_shift (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 rx_i,
    input  logic                 tick16_i,
    input  logic                 bit_end_i,
    input  logic                 shift_en_i,
    output logic                 rx_level_o,
    output logic                 rx_edge_o,
    output logic                 cur_bit_o,
    output uart_pkg::uart_byte_t data_o
);
    import uart_pkg::*;

    logic [2:0]    rx_hist;    // [1:0] synchronizer, [2] last level
    sample_count_t ones_cnt;
    uart_byte_t    shift_q;
    uart_byte_t    data_q;
    logic          frame_full; // all data bits in, stop bit pending

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_hist <= '1; // idle line
        end else begin
            rx_hist <= {rx_hist[1:0], rx_i};
        end
    end

    assign rx_level_o = rx_hist[1];
    assign rx_edge_o  = rx_hist[2] ^ rx_hist[1];

    // high samples in the current bit
    always_ff @(posedge clk) begin
        if (reset_i || bit_end_i) begin
            ones_cnt <= '0;
        end else if (tick16_i && rx_level_o) begin
            ones_cnt <= ones_cnt + 1'b1;
        end
    end

    assign cur_bit_o = (ones_cnt > MAJORITY);

    always_ff @(posedge clk) begin
        if (bit_end_i && shift_en_i) begin
            shift_q <= {cur_bit_o, shift_q[DATA_W-1:1]}; // lsb first
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frame_full <= 1'b0;
        end else if (bit_end_i) begin
            frame_full <= shift_en_i;
        end
    end

    // only a good stop bit updates the output byte
    always_ff @(posedge clk) begin
        if (bit_end_i && !shift_en_i && frame_full && cur_bit_o) begin
            data_q <= shift_q;
        end
    end

    assign data_o = data_q;

endmodule

// ==== logic/uart_baud_gen.sv ====
// uart baud tick generator
module uart_baud_gen #(
    parameter uart_pkg::div_count_t baud16_div = uart_pkg::DEFAULT_DIV
) (
    input  logic clk,
    input  logic reset_i,
    output logic tick16_o,
    output logic bit_tick_o
);
    import uart_pkg::*;

    div_count_t div_cnt;
    logic [3:0] tick_cnt;   // tick16 position within a bit
    logic       bit_tick_q;

    // period is baud16_div + 1 clocks
    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_cnt <= baud16_div;
        end else if (div_cnt == '0) begin
            div_cnt <= baud16_div;
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    assign tick16_o = (div_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tick_cnt <= '0;
        end else if (tick16_o) begin
            tick_cnt <= tick_cnt + 1'b1; // wraps every 16 ticks
        end
    end

    // every sixteenth tick, one clock late
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bit_tick_q <= 1'b0;
        end else begin
            bit_tick_q <= tick16_o && (tick_cnt == '0);
        end
    end

    assign bit_tick_o = bit_tick_q;

endmodule

// ==== logic/uart_pkg.sv ====
// uart shared definitions
package uart_pkg;

    localparam int DIV_W      = 11;
    localparam int DATA_W     = 8;
    localparam int TX_FRAME_W = 11; // idle, start, 8 data, stop

    typedef logic [DATA_W-1:0] uart_byte_t;
    typedef logic [DIV_W-1:0]  div_count_t;
    typedef logic [4:0]        sample_count_t; // 16 closes a bit
    typedef logic [3:0]        bit_count_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // 50 MHz / (16 * 326) is about 9600 baud
    localparam div_count_t DEFAULT_DIV = 11'd325;

    localparam sample_count_t SAMPLES_PER_BIT = 5'd16;
    localparam sample_count_t MAJORITY        = 5'd8; // more highs than this reads as 1

    // edges after this point close the bit, earlier ones only realign
    localparam sample_count_t HALF_BIT = 5'd8;

    localparam bit_count_t LAST_DATA_BIT = 4'd7;

    // ticks from load until the stop bit has gone out
    localparam bit_count_t TX_DONE = 4'd11;

endpackage
